/* verilog.f */
riscv_v_pkg.sv
riscv_v_op_decode.sv
riscv_v_bw_and.sv
riscv_v_bw_or_xor.sv
riscv_v_logic_writeback.sv
riscv_v_logic_unit.sv
tb_riscv_v_logic_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the vector logical unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_riscv_v_logic_unit \
    -f verilog.f -o tb_sim || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/tb_sim 2>&1)"
echo "$sim_out"

echo "$sim_out" | grep -qx "All checks passed" \
    && echo "Result: PASS" \
    || { echo "Result: FAIL"; exit 1; }

/* tb_riscv_v_logic_unit.sv */
`timescale 1ns/1ps
// Testbench for the vector logical unit
// Random and directed requests, a queue-based model of the expected responses,
// assertions on data, latency and handshake stability

module tb_riscv_v_logic_unit;

    localparam int TIMEOUT_CYCLES = 2000;

    logic                             clk;
    logic                             reset;
    riscv_v_pkg::riscv_v_logic_req_t  req;
    logic                             req_valid;
    logic                             req_ready;
    riscv_v_pkg::riscv_v_logic_rsp_t  rsp;
    logic                             rsp_valid;
    logic                             rsp_ready;

    // Expected responses and their accept cycles in arrival order
    riscv_v_pkg::riscv_v_logic_rsp_t  exp_q[$];
    int                               acc_q[$];
    int cyc          = 0;
    int sent_count   = 0;
    int rsp_count    = 0;
    // Error counters
    int err_data     = 0;
    int err_rsp_hold = 0;
    int err_flow     = 0;
    // Phase controls
    logic lat_check;
    logic bp_mode;

    riscv_v_logic_unit riscv_v_logic_unit_i (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Sink stalls at random only in the back-pressure phase
    initial begin
        rsp_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            rsp_ready = bp_mode ? 1'($urandom_range(0, 1)) : 1'b1;
        end
    end

    function automatic logic [63:0] apply_op(input riscv_v_pkg::riscv_v_logic_op_e op,
                                             input logic [63:0] x, input logic [63:0] y);
        case (op)
            riscv_v_pkg::LOGIC_AND: return x & y;
            riscv_v_pkg::LOGIC_OR:  return x | y;
            default:                return x ^ y;
        endcase
    endfunction

    // Reference result built from the element views
    function automatic riscv_v_pkg::riscv_v_logic_rsp_t expected_rsp(
        input riscv_v_pkg::riscv_v_logic_req_t r);
        riscv_v_pkg::riscv_v_data_u      b_adj;
        riscv_v_pkg::riscv_v_data_u      res;
        riscv_v_pkg::riscv_v_logic_rsp_t m;
        logic [63:0]                     acc;
        // Identity fill for invalid srcb bytes
        for (int i = 0; i < riscv_v_pkg::RISCV_V_NUM_BYTES_DATA; i++) begin
            if (r.srcb.valid[i]) b_adj.Byte[i] = r.srcb.data.Byte[i];
            else b_adj.Byte[i] = (r.op == riscv_v_pkg::LOGIC_AND) ? 8'hff : 8'h00;
        end
        res = '0;
        acc = (r.op == riscv_v_pkg::LOGIC_AND) ? '1 : '0;
        if (!r.is_reduct) begin
            for (int i = 0; i < riscv_v_pkg::RISCV_V_NUM_BYTES_DATA; i++) begin
                res.Byte[i] = 8'(apply_op(r.op, 64'(r.srca.data.Byte[i]), 64'(b_adj.Byte[i])));
            end
            m.byte_en = r.srca.valid;
        end else begin
            // Fold every element of both operands into the lowest one
            case (r.sew)
                riscv_v_pkg::SEW_8: begin
                    for (int e = 0; e < riscv_v_pkg::RISCV_V_NUM_BYTES_DATA; e++) begin
                        acc = apply_op(r.op, acc, 64'(r.srca.data.Byte[e]));
                        acc = apply_op(r.op, acc, 64'(b_adj.Byte[e]));
                    end
                    res.Byte[0] = acc[7:0];
                    m.byte_en   = 16'h0001;
                end
                riscv_v_pkg::SEW_16: begin
                    for (int e = 0; e < riscv_v_pkg::NUM_HALF; e++) begin
                        acc = apply_op(r.op, acc, 64'(r.srca.data.Half[e]));
                        acc = apply_op(r.op, acc, 64'(b_adj.Half[e]));
                    end
                    res.Half[0] = acc[15:0];
                    m.byte_en   = 16'h0003;
                end
                riscv_v_pkg::SEW_32: begin
                    for (int e = 0; e < riscv_v_pkg::NUM_WORD; e++) begin
                        acc = apply_op(r.op, acc, 64'(r.srca.data.Word[e]));
                        acc = apply_op(r.op, acc, 64'(b_adj.Word[e]));
                    end
                    res.Word[0] = acc[31:0];
                    m.byte_en   = 16'h000f;
                end
                default: begin
                    for (int e = 0; e < riscv_v_pkg::NUM_DWORD; e++) begin
                        acc = apply_op(r.op, acc, r.srca.data.Dword[e]);
                        acc = apply_op(r.op, acc, b_adj.Dword[e]);
                    end
                    res.Dword[0] = acc;
                    m.byte_en    = 16'h00ff;
                end
            endcase
        end
        m.result = res.Byte;
        return m;
    endfunction

    function automatic riscv_v_pkg::riscv_v_logic_req_t rand_req(
        input riscv_v_pkg::riscv_v_logic_op_e op, input logic is_reduct,
        input riscv_v_pkg::riscv_v_sew_e sew);
        riscv_v_pkg::riscv_v_logic_req_t r;
        r.op             = op;
        r.is_reduct      = is_reduct;
        r.sew            = sew;
        r.srca.data.Byte = {$urandom(), $urandom(), $urandom(), $urandom()};
        r.srca.valid     = 16'($urandom());
        r.srcb.data.Byte = {$urandom(), $urandom(), $urandom(), $urandom()};
        r.srcb.valid     = 16'($urandom());
        return r;
    endfunction

    function automatic riscv_v_pkg::riscv_v_logic_op_e random_op();
        return riscv_v_pkg::riscv_v_logic_op_e'(2'($urandom_range(0, 2)));
    endfunction

    function automatic riscv_v_pkg::riscv_v_sew_e random_sew();
        return riscv_v_pkg::riscv_v_sew_e'(2'($urandom_range(0, 3)));
    endfunction

    // Scoreboard pops before it pushes so an early response is not hidden
    always @(posedge clk) begin
        riscv_v_pkg::riscv_v_logic_rsp_t head;
        int acc_cyc;
        if (!reset) begin
            if (rsp_valid && rsp_ready) begin
                rsp_count++;
                assert (exp_q.size() != 0) else begin
                    err_data++;
                    $display("Response arrived with no request outstanding");
                end
                if (exp_q.size() != 0) begin
                    head    = exp_q.pop_front();
                    acc_cyc = acc_q.pop_front();
                    assert (rsp.result == head.result) else begin
                        err_data++;
                        $display("** Error: rsp.result got %h expected %h",
                                 rsp.result, head.result);
                    end
                    assert (rsp.byte_en == head.byte_en) else begin
                        err_data++;
                        $display("** Error: rsp.byte_en got %h expected %h",
                                 rsp.byte_en, head.byte_en);
                    end
                    // Two edges from accept to transfer without stalls
                    if (lat_check) begin
                        assert (cyc - acc_cyc == 2) else begin
                            err_data++;
                            $display("** Error: rsp latency got %h expected %h",
                                     cyc - acc_cyc, 2);
                        end
                    end
                end
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(expected_rsp(req));
                acc_q.push_back(cyc);
            end
            if (lat_check) begin
                assert (!req_valid || req_ready) else begin
                    err_data++;
                    $display("Input stalled during back-to-back requests");
                end
            end
        end
        cyc++;
    end

    assert property (@(posedge clk) disable iff (reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp)))
    else begin
        err_rsp_hold++;
        $display("Response dropped or changed while stalled");
    end

    task automatic report_counts();
        $display("Requests %0d, responses %0d, errors: data %0d, rsp hold %0d, flow %0d",
                 sent_count, rsp_count, err_data, err_rsp_hold, err_flow);
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        report_counts();
        $display("Checks failed");
        $finish;
    endtask

    // Holds req_valid high on return so requests can run back to back
    task automatic send_req(input riscv_v_pkg::riscv_v_logic_req_t r);
        int   waited;
        logic go;
        waited    = 0;
        go        = 1'b0;
        req       = r;
        req_valid = 1'b1;
        while (!go) begin
            @(negedge clk);
            go = req_ready;
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) abort_run("request was never accepted");
        end
        sent_count++;
    endtask

    task automatic idle_cycles(input int n);
        req_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain_rsp();
        int waited;
        waited    = 0;
        req_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT_CYCLES) abort_run("responses did not drain");
        end
    endtask

    initial begin
        riscv_v_pkg::riscv_v_logic_req_t r;
        int total;
        void'($urandom(32'hae0a_1444));
        reset     = 1'b1;
        req       = '0;
        req_valid = 1'b0;
        lat_check = 1'b0;
        bp_mode   = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        // Last edge still saw reset
        assert (req_ready == 1'b0 && rsp_valid == 1'b0) else begin
            err_flow++;
            $display("** Error: req_ready/rsp_valid got %h/%h expected 0/0",
                     req_ready, rsp_valid);
        end
        @(posedge clk);
        #1;
        assert (req_ready == 1'b1 && rsp_valid == 1'b0) else begin
            err_flow++;
            $display("** Error: req_ready/rsp_valid got %h/%h expected 1/0",
                     req_ready, rsp_valid);
        end

        // Bitwise with random valid masks
        repeat (30) send_req(rand_req(random_op(), 1'b0, random_sew()));
        drain_rsp();

        // Reductions per op and size with random, fully invalid and half invalid srcb
        for (int op = 0; op < 3; op++) begin
            for (int s = 0; s < 4; s++) begin
                for (int mode = 0; mode < 3; mode++) begin
                    r = rand_req(riscv_v_pkg::riscv_v_logic_op_e'(2'(op)), 1'b1,
                                 riscv_v_pkg::riscv_v_sew_e'(2'(s)));
                    if (mode == 1) r.srcb.valid = '0;
                    if (mode == 2) r.srcb.valid = 16'h0ff0;
                    send_req(r);
                end
            end
        end
        drain_rsp();

        // Back to back with the sink always ready
        lat_check = 1'b1;
        repeat (24) send_req(rand_req(random_op(), 1'($urandom_range(0, 1)), random_sew()));
        drain_rsp();
        lat_check = 1'b0;

        // Random sink stalls and random source gaps
        bp_mode = 1'b1;
        repeat (80) begin
            send_req(rand_req(random_op(), 1'($urandom_range(0, 1)), random_sew()));
            if ($urandom_range(0, 3) == 0) idle_cycles(int'($urandom_range(1, 3)));
        end
        drain_rsp();
        bp_mode = 1'b0;
        idle_cycles(4);

        assert (rsp_count == sent_count) else begin
            err_flow++;
            $display("** Error: response count got %h expected %h", rsp_count, sent_count);
        end

        report_counts();
        total = err_data + err_rsp_hold + err_flow;
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* riscv_v_logic_unit.sv */
`timescale 1ns/1ps
// Vector logical unit top
// Decode stage, AND tree, OR/XOR tree and writeback stage

module riscv_v_logic_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  riscv_v_pkg::riscv_v_logic_req_t   req,
    input  logic                              req_valid,
    output logic                              req_ready,
    output riscv_v_pkg::riscv_v_logic_rsp_t   rsp,
    output logic                              rsp_valid,
    input  logic                              rsp_ready
);

    // Decode stage slot
    riscv_v_pkg::riscv_v_logic_ctrl_t      ctrl;
    riscv_v_pkg::riscv_v_alu_data_t        srca;
    riscv_v_pkg::riscv_v_alu_data_t        srcb;
    logic                                  stage_valid;
    logic                                  stage_ready;
    // Tree outputs, zero from the disabled one
    riscv_v_pkg::riscv_v_src_byte_vector_t and_result;
    riscv_v_pkg::riscv_v_src_byte_vector_t orx_result;

    riscv_v_op_decode op_decode_i (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .ctrl        (ctrl),
        .srca        (srca),
        .srcb        (srcb),
        .stage_valid (stage_valid),
        .stage_ready (stage_ready)
    );

    riscv_v_bw_and bw_and_i (
        .ctrl   (ctrl),
        .srca   (srca),
        .srcb   (srcb),
        .result (and_result)
    );

    riscv_v_bw_or_xor bw_or_xor_i (
        .ctrl   (ctrl),
        .srca   (srca),
        .srcb   (srcb),
        .result (orx_result)
    );

    riscv_v_logic_writeback logic_writeback_i (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .srca_valid  (srca.valid),
        .and_result  (and_result),
        .orx_result  (orx_result),
        .stage_valid (stage_valid),
        .stage_ready (stage_ready),
        .rsp         (rsp),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready)
    );

endmodule

/* riscv_v_logic_writeback.sv */
`timescale 1ns/1ps
// Vector logical unit writeback stage
// Merges both tree results, keeps the lowest element for reductions,
// builds the byte mask and holds the response under back-pressure

module riscv_v_logic_writeback (
    input  logic                                      clk,
    input  logic                                      reset,
    input  riscv_v_pkg::riscv_v_logic_ctrl_t          ctrl,
    input  logic [riscv_v_pkg::RISCV_V_NUM_BYTES_DATA-1:0] srca_valid,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t     and_result,
    input  riscv_v_pkg::riscv_v_src_byte_vector_t     orx_result,
    input  logic                                      stage_valid,
    output logic                                      stage_ready,
    output riscv_v_pkg::riscv_v_logic_rsp_t           rsp,
    output logic                                      rsp_valid,
    input  logic                                      rsp_ready
);

    // Both tree outputs, only one tree is ever on
    riscv_v_pkg::riscv_v_data_u       merged;
    // Lowest element only, rest zero
    riscv_v_pkg::riscv_v_data_u       reduced;
    // Bytes of the lowest element
    logic [riscv_v_pkg::RISCV_V_NUM_BYTES_DATA-1:0] elem_en;
    // Response before the output register
    riscv_v_pkg::riscv_v_logic_rsp_t  rsp_d;
    // Output register takes a new response
    logic                             load;

    assign merged.Byte = and_result | orx_result;

    // Output register free when empty or being drained
    assign stage_ready = ~rsp_valid | rsp_ready;
    assign load        = stage_ready & stage_valid;

    // Lowest element through the view of the element size
    always_comb begin
        reduced = '0;
        elem_en = '0;
        case (ctrl.sew)
            riscv_v_pkg::SEW_8: begin
                reduced.Byte[0] = merged.Byte[0];
                elem_en[0]      = 1'b1;
            end
            riscv_v_pkg::SEW_16: begin
                reduced.Half[0] = merged.Half[0];
                elem_en[1:0]    = '1;
            end
            riscv_v_pkg::SEW_32: begin
                reduced.Word[0] = merged.Word[0];
                elem_en[3:0]    = '1;
            end
            default: begin
                reduced.Dword[0] = merged.Dword[0];
                elem_en[7:0]     = '1;
            end
        endcase
    end

    always_comb begin
        if (ctrl.is_reduct_n) begin
            // Bitwise writes every byte valid in srca
            rsp_d.result  = merged.Byte;
            rsp_d.byte_en = srca_valid;
        end else begin
            rsp_d.result  = reduced.Byte;
            rsp_d.byte_en = elem_en;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (stage_ready) begin
            rsp_valid <= stage_valid;
        end
    end

    // Response data held while the sink stalls
    always_ff @(posedge clk) begin
        if (load) begin
            rsp <= rsp_d;
        end
    end

endmodule

/* riscv_v_bw_or_xor.sv */
`timescale 1ns/1ps
// Vector bitwise and reduction OR or XOR
// Same byte tree as the AND block, each block combines by the selected operation

module riscv_v_bw_or_xor (
    input  riscv_v_pkg::riscv_v_logic_ctrl_t       ctrl,
    input  riscv_v_pkg::riscv_v_alu_data_t         srca,
    input  riscv_v_pkg::riscv_v_alu_data_t         srcb,
    output riscv_v_pkg::riscv_v_src_byte_vector_t  result
);

    // Tree enable, either operation
    logic                                  orx_en;
    // srca masked by the enable
    riscv_v_pkg::riscv_v_src_byte_vector_t srca_gated;
    // First input of each byte block
    riscv_v_pkg::riscv_v_src_byte_vector_t srca_bw;
    // Second input of each byte block
    riscv_v_pkg::riscv_v_src_byte_vector_t srcb_bw;
    // Byte block outputs
    riscv_v_pkg::riscv_v_src_byte_vector_t result_bw;

    // One byte block, XOR when selected and OR otherwise
    function automatic logic [riscv_v_pkg::BYTE_WIDTH-1:0] orx_byte(
        input logic [riscv_v_pkg::BYTE_WIDTH-1:0] a,
        input logic [riscv_v_pkg::BYTE_WIDTH-1:0] b,
        input logic                               use_xor
    );
        return use_xor ? (a ^ b) : (a | b);
    endfunction

    assign orx_en = ctrl.is_or | ctrl.is_xor;

    for (genvar i = 0; i < riscv_v_pkg::RISCV_V_NUM_BYTES_DATA; i++) begin : gen_byte_in
        assign srca_gated[i] = srca.data.Byte[i] & {riscv_v_pkg::BYTE_WIDTH{orx_en}};
        // Invalid srcb byte is zero, neutral for OR and XOR
        // Gating srcb too keeps a disabled tree at zero
        assign srcb_bw[i] = srcb.data.Byte[i]
                          & {riscv_v_pkg::BYTE_WIDTH{srcb.valid[i] & orx_en}};
    end

    // Top byte first so every block reads finished results above it
    always_comb begin
        logic lower_ok;

        result_bw = '0;
        srca_bw   = srca_gated;
        for (int blk = riscv_v_pkg::RISCV_V_NUM_BYTES_DATA - 1; blk >= 0; blk--) begin
            lower_ok = 1'b1;
            for (int k = 0; k < riscv_v_pkg::OSIZE_BITS; k++) begin
                if (blk[k]) begin
                    lower_ok = lower_ok & ctrl.is_greater_osize_vector[k];
                end else if (ctrl.is_reduct && ctrl.osize_vector[k] && lower_ok) begin
                    // Merge across the element boundary with the same operation
                    srca_bw[blk] = orx_byte(srca_bw[blk], result_bw[blk + (1 << k)],
                                            ctrl.is_xor);
                end
            end
            result_bw[blk] = orx_byte(srca_bw[blk], srcb_bw[blk], ctrl.is_xor);
        end
    end

    assign result = result_bw;

endmodule

/* riscv_v_bw_and.sv */
`timescale 1ns/1ps
// Vector bitwise and reduction AND
// Sixteen byte blocks, chained into a reduction tree across element boundaries

module riscv_v_bw_and (
    input  riscv_v_pkg::riscv_v_logic_ctrl_t       ctrl,
    input  riscv_v_pkg::riscv_v_alu_data_t         srca,
    input  riscv_v_pkg::riscv_v_alu_data_t         srcb,
    output riscv_v_pkg::riscv_v_src_byte_vector_t  result
);

    // srca masked by the AND enable
    riscv_v_pkg::riscv_v_src_byte_vector_t srca_gated;
    // First input of each byte block
    riscv_v_pkg::riscv_v_src_byte_vector_t srca_bw;
    // Second input of each byte block
    riscv_v_pkg::riscv_v_src_byte_vector_t srcb_bw;
    // Byte block outputs
    riscv_v_pkg::riscv_v_src_byte_vector_t result_bw;

    for (genvar i = 0; i < riscv_v_pkg::RISCV_V_NUM_BYTES_DATA; i++) begin : gen_byte_in
        // Disabled tree sees zero on A so every block outputs zero
        assign srca_gated[i] = srca.data.Byte[i] & {riscv_v_pkg::BYTE_WIDTH{ctrl.is_and}};
        // Invalid srcb byte is all ones, neutral for AND
        assign srcb_bw[i] = srcb.data.Byte[i] | {riscv_v_pkg::BYTE_WIDTH{~srcb.valid[i]}};
    end

    // Blocks evaluated from the top byte down
    // each one only reads results of blocks above it
    always_comb begin
        logic lower_ok;

        result_bw = '0;
        srca_bw   = srca_gated;
        for (int blk = riscv_v_pkg::RISCV_V_NUM_BYTES_DATA - 1; blk >= 0; blk--) begin
            lower_ok = 1'b1;
            for (int k = 0; k < riscv_v_pkg::OSIZE_BITS; k++) begin
                if (blk[k]) begin
                    // Set bit below the element size keeps the byte lane
                    lower_ok = lower_ok & ctrl.is_greater_osize_vector[k];
                end else if (ctrl.is_reduct && ctrl.osize_vector[k] && lower_ok) begin
                    // Pull the subtree 2**k above across an element boundary
                    srca_bw[blk] = srca_bw[blk] & result_bw[blk + (1 << k)];
                end
            end
            // Top byte has every bit set and sees only its gated srca
            result_bw[blk] = srca_bw[blk] & srcb_bw[blk];
        end
    end

    assign result = result_bw;

endmodule

/* riscv_v_op_decode.sv */
`timescale 1ns/1ps
// Vector logical unit decode stage
// Accepts a request, decodes op and element size into control vectors
// and holds them with both operands as one pipeline slot

module riscv_v_op_decode (
    input  logic                              clk,
    input  logic                              reset,
    input  riscv_v_pkg::riscv_v_logic_req_t   req,
    input  logic                              req_valid,
    output logic                              req_ready,
    output riscv_v_pkg::riscv_v_logic_ctrl_t  ctrl,
    output riscv_v_pkg::riscv_v_alu_data_t    srca,
    output riscv_v_pkg::riscv_v_alu_data_t    srcb,
    output logic                              stage_valid,
    input  logic                              stage_ready
);

    // Decoded control before the register
    riscv_v_pkg::riscv_v_logic_ctrl_t ctrl_d;
    // Low during reset and set on the first edge after it
    logic                             in_ready_en;
    // Request transfer this cycle
    logic                             accept;

    // Slot can take a new request when empty or draining this cycle
    assign req_ready = in_ready_en & (~stage_valid | stage_ready);
    assign accept    = req_valid & req_ready;

    always_comb begin
        ctrl_d = '0;

        // One-hot tree enables, unknown op leaves both trees off
        case (req.op)
            riscv_v_pkg::LOGIC_AND: ctrl_d.is_and = 1'b1;
            riscv_v_pkg::LOGIC_OR:  ctrl_d.is_or  = 1'b1;
            riscv_v_pkg::LOGIC_XOR: ctrl_d.is_xor = 1'b1;
            default:                ctrl_d.is_and = 1'b0;
        endcase

        ctrl_d.is_reduct   = req.is_reduct;
        ctrl_d.is_reduct_n = ~req.is_reduct;
        ctrl_d.sew         = req.sew;

        // Element is 2**sew bytes
        // Level k crosses elements once 2**k reaches the element size
        for (int k = 0; k < riscv_v_pkg::OSIZE_BITS; k++) begin
            ctrl_d.osize_vector[k]            = (k >= int'(req.sew));
            ctrl_d.is_greater_osize_vector[k] = (int'(req.sew) > k);
        end
    end

    // Handshake state
    always_ff @(posedge clk) begin
        if (reset) begin
            in_ready_en <= 1'b0;
            stage_valid <= 1'b0;
        end else begin
            in_ready_en <= 1'b1;
            // Fill, refill or empty only when the slot may move
            if (req_ready) begin
                stage_valid <= req_valid;
            end
        end
    end

    // Pipeline slot contents
    always_ff @(posedge clk) begin
        if (accept) begin
            ctrl <= ctrl_d;
            srca <= req.srca;
            srcb <= req.srcb;
        end
    end

endmodule

/* riscv_v_pkg.sv */
// Shared definitions for the vector logical unit
// Sizes, operation and element-size codes, the operand union and the stage structs

package riscv_v_pkg;

    // Operand geometry
    localparam int BYTE_WIDTH             = 8;
    localparam int RISCV_V_NUM_BYTES_DATA = 16;
    // log2 of the byte count, one bit per tree level
    localparam int OSIZE_BITS             = 4;

    // Element widths for the wider union views
    localparam int HALF_WIDTH  = 2 * BYTE_WIDTH;
    localparam int WORD_WIDTH  = 4 * BYTE_WIDTH;
    localparam int DWORD_WIDTH = 8 * BYTE_WIDTH;

    // Element counts per operand for each view
    localparam int NUM_HALF  = RISCV_V_NUM_BYTES_DATA / 2;
    localparam int NUM_WORD  = RISCV_V_NUM_BYTES_DATA / 4;
    localparam int NUM_DWORD = RISCV_V_NUM_BYTES_DATA / 8;

    // Logical operation select
    typedef enum logic [1:0] {
        LOGIC_AND = 2'd0,
        LOGIC_OR  = 2'd1,
        LOGIC_XOR = 2'd2
    } riscv_v_logic_op_e;

    // Element size, 1, 2, 4 or 8 bytes
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } riscv_v_sew_e;

    // One bit per tree level
    typedef logic [OSIZE_BITS-1:0] osize_vector_t;

    typedef logic [RISCV_V_NUM_BYTES_DATA-1:0][BYTE_WIDTH-1:0] riscv_v_src_byte_vector_t;

    // Same 128 bits seen as bytes or as whole elements
    typedef union packed {
        riscv_v_src_byte_vector_t                Byte;
        logic [NUM_HALF-1:0][HALF_WIDTH-1:0]     Half;
        logic [NUM_WORD-1:0][WORD_WIDTH-1:0]     Word;
        logic [NUM_DWORD-1:0][DWORD_WIDTH-1:0]   Dword;
    } riscv_v_data_u;

    // Operand with per-byte valid
    typedef struct packed {
        riscv_v_data_u                     data;
        logic [RISCV_V_NUM_BYTES_DATA-1:0] valid;
    } riscv_v_alu_data_t;

    // Request word on the input handshake
    typedef struct packed {
        riscv_v_logic_op_e op;
        logic              is_reduct;
        riscv_v_sew_e      sew;
        riscv_v_alu_data_t srca;
        riscv_v_alu_data_t srcb;
    } riscv_v_logic_req_t;

    // Decoded control held in the decode stage
    typedef struct packed {
        logic          is_and;
        logic          is_or;
        logic          is_xor;
        logic          is_reduct;
        logic          is_reduct_n;
        riscv_v_sew_e  sew;
        // Levels at or above the element size, these cross elements
        osize_vector_t osize_vector;
        // Levels below the element size
        osize_vector_t is_greater_osize_vector;
    } riscv_v_logic_ctrl_t;

    // Response word on the output handshake
    typedef struct packed {
        riscv_v_src_byte_vector_t          result;
        logic [RISCV_V_NUM_BYTES_DATA-1:0] byte_en;
    } riscv_v_logic_rsp_t;

endpackage
